// File: src/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regIndexWidth = 5;
    localparam int multSteps = 32;

    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        JUMP  = 6'b000010,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001
    } opcodeT;

    typedef enum logic [5:0] {
        ADD  = 6'b100000,
        SUB  = 6'b100010,
        AND  = 6'b100100,
        JR   = 6'b001000,
        MFHI = 6'b010000,
        MFLO = 6'b010010,
        MULT = 6'b011000
    } functT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        ALUWRITE,
        IMMWRITE,
        MULTBUSY,
        WAITSTATE
    } cpuStateT;

    typedef enum logic [1:0] {aluPass, aluAdd, aluSub, aluAnd} aluOpT;
    typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm} srcBT;
    typedef enum logic [1:0] {pcIncrement, pcJump, pcRegA} pcSourceT;
    typedef enum logic [1:0] {writeAluOut, writeHi, writeLo} writeSourceT;

    typedef struct packed {
        logic        pcWrite;
        logic        irWrite;
        pcSourceT    pcSource;
        aluOpT       aluOp;
        logic        srcA;
        srcBT        srcB;
        logic        aluOutWrite;
        logic        operandWrite;
        logic        regWrite;
        logic        destIsRd;
        writeSourceT writeSource;
        logic        multStart;
    } ctrlWordT;

    localparam ctrlWordT ctrlIdle = '{
        pcWrite:      1'b0,
        irWrite:      1'b0,
        pcSource:     pcIncrement,
        aluOp:        aluPass,
        srcA:         1'b0,
        srcB:         srcBReg,
        aluOutWrite:  1'b0,
        operandWrite: 1'b0,
        regWrite:     1'b0,
        destIsRd:     1'b0,
        writeSource:  writeAluOut,
        multStart:    1'b0
    };

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic [dataWidth-1:0] adr;
    } wbReqT;

    typedef struct packed {
        logic                 ack;
        logic [dataWidth-1:0] dat;
    } wbRspT;

    typedef struct packed {
        logic                     valid;
        logic [regIndexWidth-1:0] index;
        logic [dataWidth-1:0]     value;
    } writeBackT;

    typedef struct packed {
        opcodeT                   opcode;
        logic [regIndexWidth-1:0] rs;
        logic [regIndexWidth-1:0] rt;
        logic [regIndexWidth-1:0] rd;
        logic [4:0]               shamt;
        functT                    funct;
    } instrT;

endpackage

// File: src/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
    input  logic             clock,
    input  logic             rst,
    input  cpuPkg::opcodeT   opcode,
    input  cpuPkg::functT    funct,
    input  logic             fetchDone,
    input  logic             aluOverflow,
    input  logic             multLast,
    output cpuPkg::ctrlWordT ctrl,
    output logic             multBusy,
    output cpuPkg::cpuStateT state
);
    import cpuPkg::*;

    cpuStateT nextState;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    assign multBusy = (state == MULTBUSY);

    always_comb begin
        ctrl = ctrlIdle;
        nextState = state;
        case (state)
            FETCH: begin
                // PC+4 goes through the ALU while the bus cycle runs
                ctrl.aluOp = aluAdd;
                ctrl.srcB = srcBFour;
                if (fetchDone) begin
                    ctrl.pcWrite = 1'b1;
                    ctrl.irWrite = 1'b1;
                    nextState = DECODE;
                end
            end
            DECODE: begin
                ctrl.operandWrite = 1'b1;
                nextState = EXECUTE;
            end
            EXECUTE: begin
                nextState = WAITSTATE;
                case (opcode)
                    RTYPE: begin
                        case (funct)
                            ADD, SUB, AND: begin
                                ctrl.srcA = 1'b1;
                                ctrl.srcB = srcBReg;
                                ctrl.aluOutWrite = 1'b1;
                                nextState = ALUWRITE;
                                case (funct)
                                    ADD: ctrl.aluOp = aluAdd;
                                    SUB: ctrl.aluOp = aluSub;
                                    default: ctrl.aluOp = aluAnd;
                                endcase
                            end
                            JR: begin
                                ctrl.pcWrite = 1'b1;
                                ctrl.pcSource = pcRegA;
                            end
                            MFHI, MFLO: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.destIsRd = 1'b1;
                                ctrl.writeSource = (funct == MFHI) ? writeHi : writeLo;
                            end
                            MULT: begin
                                ctrl.multStart = 1'b1;
                                nextState = MULTBUSY;
                            end
                            default: nextState = WAITSTATE;
                        endcase
                    end
                    JUMP: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSource = pcJump;
                    end
                    ADDI, ADDIU: begin
                        ctrl.aluOp = aluAdd;
                        ctrl.srcA = 1'b1;
                        ctrl.srcB = srcBImm;
                        ctrl.aluOutWrite = 1'b1;
                        nextState = IMMWRITE;
                    end
                    default: nextState = WAITSTATE;
                endcase
            end
            ALUWRITE: begin
                // Overflow drops the write and the PC already points past it
                if (!aluOverflow) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.destIsRd = 1'b1;
                    ctrl.writeSource = writeAluOut;
                end
                nextState = WAITSTATE;
            end
            IMMWRITE: begin
                ctrl.regWrite = 1'b1;
                ctrl.destIsRd = 1'b0;
                ctrl.writeSource = writeAluOut;
                nextState = WAITSTATE;
            end
            MULTBUSY: begin
                if (multLast) begin
                    nextState = WAITSTATE;
                end
            end
            WAITSTATE: nextState = FETCH;
            default: nextState = FETCH;
        endcase
    end

    // Register and PC updates only meet in the execute step
    assert property (@(posedge clock) disable iff (rst)
        (state != EXECUTE) |-> !(ctrl.regWrite && ctrl.pcWrite));

endmodule

// File: src/multCounter.sv
`timescale 1ns/1ps

module multCounter #(
    parameter int STEPS = 32
) (
    input  logic clock,
    input  logic rst,
    input  logic multStart,
    input  logic multBusy,
    output logic multLast
);
    localparam int CountWidth = $clog2(STEPS);

    logic [CountWidth-1:0] count;

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (multStart) begin
            count <= CountWidth'(STEPS - 1);
        end else if (multBusy && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign multLast = multBusy && (count == '0);

    // A new multiply must wait for the previous one to finish
    assert property (@(posedge clock) disable iff (rst) multStart |-> !multBusy);

endmodule

// File: src/shiftMultiplier.sv
`timescale 1ns/1ps

module shiftMultiplier #(
    parameter int WIDTH = 32
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             multStart,
    input  logic             multBusy,
    input  logic [WIDTH-1:0] multiplicand,
    input  logic [WIDTH-1:0] multiplier,
    output logic [WIDTH-1:0] hi,
    output logic [WIDTH-1:0] lo
);
    // Upper half collects partial sums, lower half shifts the multiplier out
    logic [2*WIDTH-1:0] acc;
    logic [WIDTH-1:0]   mcand;
    logic [WIDTH:0]     partial;

    always_comb begin
        partial = {1'b0, acc[2*WIDTH-1:WIDTH]};
        if (acc[0]) begin
            partial = partial + {1'b0, mcand};
        end
    end

    always_ff @(posedge clock) begin
        if (multStart) begin
            mcand <= multiplicand;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            acc <= '0;
        end else if (multStart) begin
            acc <= {{WIDTH{1'b0}}, multiplier};
        end else if (multBusy) begin
            // Carry out lands in the top bit after the shift
            acc <= {partial, acc[WIDTH-1:1]};
        end
    end

    assign hi = acc[2*WIDTH-1:WIDTH];
    assign lo = acc[WIDTH-1:0];

endmodule

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
    parameter int WIDTH = 32
) (
    input  logic             clock,
    input  logic             rst,
    input  cpuPkg::ctrlWordT ctrl,
    input  logic [WIDTH-1:0] pc,
    input  logic [WIDTH-1:0] regA,
    input  logic [WIDTH-1:0] regB,
    input  logic [WIDTH-1:0] immediate,
    output logic [WIDTH-1:0] aluResult,
    output logic [WIDTH-1:0] aluOut,
    output logic             aluOverflow
);
    import cpuPkg::*;

    logic [WIDTH-1:0] opA;
    logic [WIDTH-1:0] opB;
    logic             signedOvf;

    always_comb begin
        opA = ctrl.srcA ? regA : pc;
        case (ctrl.srcB)
            srcBFour: opB = WIDTH'(4);
            srcBImm:  opB = immediate;
            default:  opB = regB;
        endcase
    end

    always_comb begin
        signedOvf = 1'b0;
        case (ctrl.aluOp)
            aluAdd: begin
                aluResult = opA + opB;
                signedOvf = (opA[WIDTH-1] == opB[WIDTH-1]) &&
                            (aluResult[WIDTH-1] != opA[WIDTH-1]);
            end
            aluSub: begin
                aluResult = opA - opB;
                signedOvf = (opA[WIDTH-1] != opB[WIDTH-1]) &&
                            (aluResult[WIDTH-1] != opA[WIDTH-1]);
            end
            aluAnd:  aluResult = opA & opB;
            default: aluResult = opA;
        endcase
    end

    always_ff @(posedge clock) begin
        if (ctrl.aluOutWrite) begin
            aluOut <= aluResult;
        end
    end

    // Only register-register ops trap, so the flag is a one-cycle pulse
    always_ff @(posedge clock) begin
        if (rst) begin
            aluOverflow <= 1'b0;
        end else begin
            aluOverflow <= ctrl.aluOutWrite && (ctrl.srcB == srcBReg) && signedOvf;
        end
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int WIDTH = 32
) (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::ctrlWordT  ctrl,
    input  cpuPkg::instrT     instr,
    input  logic [WIDTH-1:0]  aluOut,
    input  logic [WIDTH-1:0]  hi,
    input  logic [WIDTH-1:0]  lo,
    output logic [WIDTH-1:0]  regA,
    output logic [WIDTH-1:0]  regB,
    output cpuPkg::writeBackT writeBack
);
    import cpuPkg::*;

    logic [WIDTH-1:0] regs [2**regIndexWidth];
    logic [WIDTH-1:0] writeValue;

    always_comb begin
        case (ctrl.writeSource)
            writeHi: writeValue = hi;
            writeLo: writeValue = lo;
            default: writeValue = aluOut;
        endcase
        writeBack.valid = ctrl.regWrite;
        writeBack.index = ctrl.destIsRd ? instr.rd : instr.rt;
        writeBack.value = writeValue;
    end

    // Register zero is never stored
    always_ff @(posedge clock) begin
        if (writeBack.valid && writeBack.index != '0) begin
            regs[writeBack.index] <= writeBack.value;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            regA <= '0;
            regB <= '0;
        end else if (ctrl.operandWrite) begin
            regA <= (instr.rs == '0) ? '0 : regs[instr.rs];
            regB <= (instr.rt == '0) ? '0 : regs[instr.rt];
        end
    end

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                          clock,
    input  logic                          rst,
    input  cpuPkg::ctrlWordT              ctrl,
    input  cpuPkg::cpuStateT              state,
    input  logic [cpuPkg::dataWidth-1:0]  aluResult,
    input  logic [cpuPkg::dataWidth-1:0]  regA,
    input  cpuPkg::wbRspT                 wbRsp,
    output cpuPkg::wbReqT                 wbReq,
    output cpuPkg::instrT                 instr,
    output logic [cpuPkg::dataWidth-1:0]  pc,
    output logic                          fetchDone
);
    import cpuPkg::*;

    logic                 reqActive;
    logic [dataWidth-1:0] jumpTarget;

    // Raised from WAITSTATE so the request is up in the first FETCH cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            reqActive <= 1'b0;
        end else if (reqActive && wbRsp.ack) begin
            reqActive <= 1'b0;
        end else if (state == FETCH || state == WAITSTATE) begin
            reqActive <= 1'b1;
        end
    end

    assign wbReq.cyc = reqActive;
    assign wbReq.stb = reqActive;
    assign wbReq.adr = pc;
    assign fetchDone = reqActive && wbRsp.ack;

    always_ff @(posedge clock) begin
        if (ctrl.irWrite) begin
            instr <= instrT'(wbRsp.dat);
        end
    end

    // PC already holds PC+4 by the time a jump executes
    assign jumpTarget = {pc[dataWidth-1:dataWidth-4], instr.rs, instr.rt, instr.rd,
                         instr.shamt, instr.funct, 2'b00};

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pcWrite) begin
            case (ctrl.pcSource)
                pcJump:  pc <= jumpTarget;
                pcRegA:  pc <= regA;
                default: pc <= aluResult;
            endcase
        end
    end

    // A new strobe only starts with cyc and only for an instruction fetch
    assert property (@(posedge clock) disable iff (rst)
        $rose(wbReq.stb) |-> wbReq.cyc && (state == FETCH));

endmodule

// File: src/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::wbRspT     wbRsp,
    output cpuPkg::wbReqT     wbReq,
    output cpuPkg::writeBackT writeBack,
    output logic              overflow
);
    import cpuPkg::*;

    ctrlWordT             ctrl;
    cpuStateT             state;
    instrT                instr;
    logic                 fetchDone;
    logic                 aluOverflow;
    logic                 multLast;
    logic                 multBusy;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] hi;
    logic [dataWidth-1:0] lo;
    logic [dataWidth-1:0] immediate;

    // Sign-extended low half of the instruction
    assign immediate = {{(dataWidth-16){instr[15]}}, instr[15:0]};
    assign overflow = aluOverflow;

    controlFsm controlFsm_i (
        .clock(clock), .rst(rst), .opcode(instr.opcode), .funct(instr.funct),
        .fetchDone(fetchDone), .aluOverflow(aluOverflow), .multLast(multLast),
        .ctrl(ctrl), .multBusy(multBusy), .state(state)
    );

    multCounter #(.STEPS(multSteps)) multCounter_i (
        .clock(clock), .rst(rst), .multStart(ctrl.multStart), .multBusy(multBusy),
        .multLast(multLast)
    );

    shiftMultiplier #(.WIDTH(dataWidth)) shiftMultiplier_i (
        .clock(clock), .rst(rst), .multStart(ctrl.multStart), .multBusy(multBusy),
        .multiplicand(regA), .multiplier(regB), .hi(hi), .lo(lo)
    );

    aluUnit #(.WIDTH(dataWidth)) aluUnit_i (
        .clock(clock), .rst(rst), .ctrl(ctrl), .pc(pc), .regA(regA), .regB(regB),
        .immediate(immediate), .aluResult(aluResult), .aluOut(aluOut),
        .aluOverflow(aluOverflow)
    );

    regFile #(.WIDTH(dataWidth)) regFile_i (
        .clock(clock), .rst(rst), .ctrl(ctrl), .instr(instr), .aluOut(aluOut),
        .hi(hi), .lo(lo), .regA(regA), .regB(regB), .writeBack(writeBack)
    );

    fetchUnit fetchUnit_i (
        .clock(clock), .rst(rst), .ctrl(ctrl), .state(state), .aluResult(aluResult),
        .regA(regA), .wbRsp(wbRsp), .wbReq(wbReq), .instr(instr), .pc(pc),
        .fetchDone(fetchDone)
    );

endmodule

// File: verif/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import cpuPkg::*;

    localparam int maxLines = 64;
    localparam int fieldsPerLine = 5;
    localparam int memWords = 64;

    logic      clock;
    logic      rst;
    wbRspT     wbRsp;
    wbReqT     wbReq;
    writeBackT writeBack;
    logic      overflow;

    // Each case line is fetch address, word, result kind, write index, write value
    logic [31:0] caseData [fieldsPerLine*maxLines];
    logic [31:0] mem [memWords];
    int          numCases;
    int          caseIdx;
    logic        awaitResult;
    logic        busActive;
    logic        newFetch;
    logic [1:0]  waitLeft;
    integer      seed;
    integer      randVal;
    int          cycleCount;
    int          cycleLimit;

    mipsCore mipsCore_i (
        .clock(clock),
        .rst(rst),
        .wbRsp(wbRsp),
        .wbReq(wbReq),
        .writeBack(writeBack),
        .overflow(overflow)
    );

    always #50 clock = ~clock;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        stopRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic checkWriteBack(input writeBackT got, input writeBackT expected);
        if (got.valid !== expected.valid) begin
            reportMismatch("writeBack.valid", got.valid, expected.valid);
        end else if (expected.valid && got.index !== expected.index) begin
            reportMismatch("writeBack.index", got.index, expected.index);
        end else if (expected.valid && got.value !== expected.value) begin
            reportMismatch("writeBack.value", got.value, expected.value);
        end
    endtask

    task automatic checkFetch(input wbReqT got, input wbReqT expected);
        if (got.cyc !== expected.cyc) begin
            reportMismatch("wbReq.cyc", got.cyc, expected.cyc);
        end else if (got.stb !== expected.stb) begin
            reportMismatch("wbReq.stb", got.stb, expected.stb);
        end else if (got.adr !== expected.adr) begin
            reportMismatch("wbReq.adr", got.adr, expected.adr);
        end
    endtask

    task automatic checkOverflow(input logic got, input logic expected);
        if (got !== expected) begin
            reportMismatch("overflow", got, expected);
        end
    endtask

    // Memory answers after 0 to 3 wait cycles
    task automatic serveMemory();
        if (wbReq.cyc && wbReq.stb) begin
            if (!busActive) begin
                busActive = 1'b1;
                randVal = $random(seed);
                waitLeft = randVal[1:0];
            end
            if (waitLeft == 2'd0) begin
                wbRsp.ack = 1'b1;
                wbRsp.dat = mem[wbReq.adr[7:2]];
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end else begin
            busActive = 1'b0;
            wbRsp = '0;
        end
    endtask

    // Every fetch, write and overflow must match the next expected event
    task automatic followEvents(input logic fetchSeen);
        int        base;
        wbReqT     expReq;
        writeBackT expWb;
        base = fieldsPerLine * caseIdx;
        if (!awaitResult) begin
            if (writeBack.valid || overflow) begin
                stopRun($sformatf("Write or overflow seen before the fetch of case %0d",
                                  caseIdx));
            end else if (fetchSeen) begin
                expReq.cyc = 1'b1;
                expReq.stb = 1'b1;
                expReq.adr = caseData[base];
                checkFetch(wbReq, expReq);
                if (caseData[base+2] == 32'd0) begin
                    caseIdx = caseIdx + 1;
                end else begin
                    awaitResult = 1'b1;
                end
            end
        end else if (fetchSeen) begin
            stopRun($sformatf("Next fetch started before the result of case %0d", caseIdx));
        end else if (writeBack.valid || overflow) begin
            expWb.valid = (caseData[base+2] == 32'd1);
            expWb.index = caseData[base+3][regIndexWidth-1:0];
            expWb.value = caseData[base+4];
            checkOverflow(overflow, caseData[base+2] == 32'd2);
            checkWriteBack(writeBack, expWb);
            awaitResult = 1'b0;
            caseIdx = caseIdx + 1;
        end
    endtask

    always @(negedge clock) begin
        if (!rst) begin
            newFetch = (wbReq.cyc || wbReq.stb) && !busActive;
            serveMemory();
            if (caseIdx < numCases) begin
                followEvents(newFetch);
            end
        end
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            stopRun($sformatf("Timeout after %0d cycles, case %0d of %0d not reached",
                              cycleLimit, caseIdx, numCases));
        end
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        wbRsp = '0;
        seed = 32'h1d20;
        caseIdx = 0;
        awaitResult = 1'b0;
        busActive = 1'b0;
        waitLeft = 2'd0;
        cycleCount = 0;
        numCases = 0;
        cycleLimit = 200;
        for (int i = 0; i < fieldsPerLine * maxLines; i++) begin
            caseData[i] = '1;
        end
        $readmemh("verif/mipsCases.txt", caseData);
        while (numCases < maxLines && caseData[fieldsPerLine*numCases] !== '1) begin
            numCases = numCases + 1;
        end
        if (numCases == 0) begin
            stopRun("No cases were read from verif/mipsCases.txt");
        end
        // Unused words jump to themselves
        for (int i = 0; i < memWords; i++) begin
            mem[i] = {JUMP, 26'(i)};
        end
        for (int i = 0; i < numCases; i++) begin
            mem[caseData[fieldsPerLine*i][7:2]] = caseData[fieldsPerLine*i+1];
        end
        cycleLimit = 50 * numCases + 200;
        repeat (3) @(negedge clock);
        rst = 1'b0;
        wait (caseIdx == numCases);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: verif/mipsCases.txt
// Columns: fetch address, instruction word, result kind (0 none, 1 write, 2 overflow),
// expected write index, expected write value
00000000 20017fff 1 01 00007fff  // addi r1, r0, 0x7fff
00000004 2402fffe 1 02 fffffffe  // addiu r2, r0, -2
00000008 00221820 1 03 00007ffd  // add r3, r1, r2
0000000c 00412022 1 04 ffff7fff  // sub r4, r2, r1
00000010 00222824 1 05 00007ffe  // and r5, r1, r2
00000014 20260001 1 06 00008000  // addi r6, r1, 1
00000018 00460018 0 00 00000000  // mult r2, r6
0000001c 00003810 1 07 00007fff  // mfhi r7, unsigned upper half
00000020 00004012 1 08 ffff0000  // mflo r8
00000024 00c60018 0 00 00000000  // mult r6, r6
00000028 00004812 1 09 40000000  // mflo r9
0000002c 01295020 2 00 00000000  // add r10, r9, r9 overflows
00000030 20200005 1 00 00008004  // addi r0, r1, 5
00000034 00015820 1 0b 00007fff  // add r11, r0, r1
00000038 08000014 0 00 00000000  // j 0x50
00000050 200c0070 1 0c 00000070  // addi r12, r0, 0x70
00000054 01800008 0 00 00000000  // jr r12
00000070 0800001c 0 00 00000000  // j 0x70

// File: filelist.f
src/cpuPkg.sv
src/controlFsm.sv
src/multCounter.sv
src/shiftMultiplier.sv
src/aluUnit.sv
src/regFile.sv
src/fetchUnit.sv
src/mipsCore.sv
verif/mipsCoreTb.sv
